//--- bench/lsu_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_assertions (
    input wire                      clk,
    input wire                      rst_n_sync,
    input wire                      ok,
    input wire                      valid_out,
    input wire lsu_pkg::mem_state_e state,
    input wire lsu_pkg::cache_req_t cache_req,
    input wire lsu_pkg::cache_rsp_t cache_rsp
);
    import lsu_pkg::*;

    // fields held until the done strobe
    req_held: assert property (@(posedge clk) disable iff (!rst_n_sync)
        cache_req.valid && !cache_rsp.done |=> $stable(cache_req))
        else $error("cache request changed before done");

    second_stalls: assert property (@(posedge clk) disable iff (!rst_n_sync)
        state == SECOND |-> !ok)
        else $error("ok high while in SECOND");

    done_once: assert property (@(posedge clk) disable iff (!rst_n_sync)
        state == DONE && valid_out |=> !(state == DONE && valid_out))
        else $error("valid_out high for two cycles in DONE");

endmodule

bind mem_access_unit lsu_assertions lsu_assertions_i (
    .clk        (clk),
    .rst_n_sync (rst_n_sync),
    .ok         (ok),
    .valid_out  (valid_out),
    .state      (state),
    .cache_req  (cache_req),
    .cache_rsp  (cache_rsp)
);

`default_nettype wire

//--- bench/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int AW       = `LSU_RAM_WORDS_LOG2 + 3;  // byte address bits
    localparam int ACCESSES = 56;                       // over all tests, rounded up
    localparam int LIMIT    = ACCESSES * (4 * `LSU_RAM_LATENCY + 8);

    logic        clk, flush, valid_in, go, valid_out, ok;
    logic [63:0] addr, store_data, load_data;
    mem_op_e     op;
    logic [7:0]  ref_mem [2**AW];   // mirrors the ram byte by byte
    logic [31:0] rng = 32'hbba4_6cbd;
    int          cycles = 0;
    int          errors = 0;
    int          mark = 0;          // errors before the current test

    lsu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout, the run did not end within %0d cycles", LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int width_of(input mem_op_e o);
        case (o)
            LD, SD:      return 8;
            LW, LWU, SW: return 4;
            LH, LHU, SH: return 2;
            default:     return 1;
        endcase
    endfunction

    function automatic logic [63:0] expected_load(input mem_op_e o, input logic [63:0] a);
        logic [63:0] v;
        int          n;
        n = width_of(o);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[a[AW-1:0] + AW'(i)];
        end
        if ((o inside {LW, LH, LB}) && (v >> (8*n - 1)) != 64'd0) begin
            v = v | (~64'd0 << (8*n));  // sign fill above the loaded bytes
        end
        return v;
    endfunction

    task automatic random_slot(output logic [63:0] a, output logic [63:0] d);
        rng = xorshift32(rng);
        a = 64'({rng[AW-1:4], 4'h0});  // even doubleword, so the next one is in range too
        rng = xorshift32(rng);
        d[63:32] = rng;
        rng = xorshift32(rng);
        d[31:0] = rng;
    endtask

    task automatic run_access(input mem_op_e o, input logic [63:0] a, input logic [63:0] d);
        valid_in   = 1'b1;
        go         = 1'b1;
        op         = o;
        addr       = a;
        store_data = d;
        do begin
            @(posedge clk);
            #1;
            if (!valid_out && ok) begin
                $display("** Error at %0t: ok high while %s is still running", $time, o.name());
                errors++;
            end
        end while (!valid_out);
        if (o inside {SD, SW, SH, SB}) begin
            for (int i = 0; i < width_of(o); i++) begin
                ref_mem[a[AW-1:0] + AW'(i)] = d[8*i +: 8];
            end
        end else if (load_data !== expected_load(o, a)) begin
            $display("** Error at %0t: %s at %h returned %h, expected %h", $time, o.name(), a,
                     load_data, expected_load(o, a));
            errors++;
        end
        valid_in = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic report(input string name);
        $display("%-9s finished, %0d errors", name, errors - mark);
        mark = errors;
    endtask

    task automatic test_aligned();
        logic [63:0] a, d;
        random_slot(a, d);
        run_access(SD, a, d);
        run_access(LD, a, 64'd0);
        run_access(LD, a, 64'd0);  // hit this time
    endtask

    task automatic test_subword();
        mem_op_e     loads [6] = '{LW, LH, LB, LWU, LHU, LBU};
        logic [63:0] a, d;
        random_slot(a, d);
        run_access(SD, a, d);
        foreach (loads[k]) begin
            for (int off = 0; off < 8; off += width_of(loads[k])) begin
                run_access(loads[k], a + 64'(off), 64'd0);
            end
        end
    endtask

    task automatic test_crossing();
        logic [63:0] a, d;
        random_slot(a, d);
        run_access(SD, a + 64'd5, d);
        run_access(LD, a + 64'd5, 64'd0);
        run_access(SW, a + 64'd6, ~d);
        run_access(LW, a + 64'd6, 64'd0);
        run_access(SH, a + 64'd7, {d[31:0], d[63:32]});
        run_access(LHU, a + 64'd7, 64'd0);
        run_access(LD, a + 64'd8, 64'd0);
    endtask

    task automatic test_masked();
        logic [63:0] a, d;
        random_slot(a, d);
        run_access(SD, a, d);
        run_access(LD, a, 64'd0);  // brings the line in
        run_access(SB, a + 64'd3, ~d);
        run_access(SH, a + 64'd6, ~d);
        run_access(LD, a, 64'd0);
    endtask

    task automatic test_nop_and_go();
        logic [63:0] a, d;
        random_slot(a, d);
        valid_in = 1'b1;
        go       = 1'b1;
        op       = NOP;
        #1;
        if (!valid_out || !ok) begin
            $display("** Error at %0t: nop gave valid_out %b ok %b", $time, valid_out, ok);
            errors++;
        end
        @(posedge clk);
        #1;
        op         = SD;
        go         = 1'b0;
        addr       = a;
        store_data = d;
        repeat (3) begin
            @(posedge clk);
            #1;
            if (valid_out || !ok) begin
                $display("** Error at %0t: go low gave valid_out %b ok %b", $time, valid_out, ok);
                errors++;
            end
        end
        run_access(SD, a, d);
        run_access(LD, a, 64'd0);
    endtask

    task automatic test_reset();
        logic [63:0] a, d;
        random_slot(a, d);
        run_access(SD, a, d);
        run_access(LD, a, 64'd0);  // line cached before the flush
        valid_in   = 1'b1;         // same store again, cut short by the flush
        go         = 1'b1;
        op         = SD;
        addr       = a;
        store_data = d;
        @(posedge clk);
        #1;
        valid_in = 1'b0;
        flush    = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
            if (valid_out || !ok) begin
                $display("** Error at %0t: flush gave valid_out %b ok %b", $time, valid_out, ok);
                errors++;
            end
        end
        flush = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        if (dut_i.dcache_i.line_valid !== '0) begin
            $display("** Error at %0t: cache lines still valid after reset", $time);
            errors++;
        end
        run_access(LD, a, 64'd0);
    endtask

    initial begin
        flush      = 1'b0;
        valid_in   = 1'b0;
        go         = 1'b0;
        addr       = 64'd0;
        store_data = 64'd0;
        op         = NOP;
        ref_mem    = '{default: 8'h00};
        repeat (2) @(posedge clk);
        #1;
        flush = 1'b1;
        repeat (2) @(posedge clk);  // synchronizer release
        #1;
        test_aligned();
        report("aligned");
        test_subword();
        report("subword");
        test_crossing();
        report("crossing");
        test_masked();
        report("masked");
        test_nop_and_go();
        report("nop_go");
        test_reset();
        report("reset");
        $display("6 tests, %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu_top.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/mem_access_unit.sv
verilog/dcache.sv
verilog/data_ram.sv
verilog/lsu_top.sv
bench/lsu_assertions.sv
bench/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module lsu_tb -f lsu_top.f -o lsu_sim > build.log 2>&1 &&
    ./obj_dir/lsu_sim > sim.log 2>&1 ||
    { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

//--- verilog/data_ram.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module data_ram (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire  lsu_pkg::cache_req_t req,
    output lsu_pkg::cache_rsp_t       rsp
);
    localparam int AW    = `LSU_RAM_WORDS_LOG2;
    localparam int LAT   = `LSU_RAM_LATENCY;
    localparam int CNT_W = $clog2(LAT + 1);

    logic [63:0]      mem [2**AW];
    logic [CNT_W-1:0] cnt;     // cycles the request has waited
    logic [AW-1:0]    word;
    logic             done;

    assign word = req.addr[3 +: AW];
    assign done = req.valid && (cnt == CNT_W'(LAT - 1));

    initial begin
        for (int i = 0; i < 2**AW; i++) begin
            mem[i] = 64'd0;
        end
    end

    // restarts after each done so back-to-back requests wait again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (done || !req.valid) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + CNT_W'(1);
        end
    end

    always @(posedge clk) begin
        if (done && req.wen) begin
            for (int b = 0; b < 8; b++) begin
                if (req.mask[b]) begin
                    mem[word][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp.done  = done;
        rsp.rdata = mem[word];
    end

endmodule

`default_nettype wire

//--- verilog/dcache.sv
`timescale 1ns/1ns
`default_nettype none
`include "lsu_settings.svh"

module dcache (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire  lsu_pkg::cache_req_t cpu_req,
    output lsu_pkg::cache_rsp_t       cpu_rsp,
    output lsu_pkg::cache_req_t       mem_req,
    input  wire  lsu_pkg::cache_rsp_t mem_rsp
);
    localparam int LINES = `LSU_CACHE_LINES;
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = `LSU_RAM_WORDS_LOG2 - IDX_W;

    logic [LINES-1:0] line_valid;
    logic [TAG_W-1:0] tag_q [LINES];
    logic [63:0]      data_q [LINES];
    logic [IDX_W-1:0] index;
    logic [TAG_W-1:0] tag;
    logic             hit;
    logic             refill;
    logic             update;

    assign index = cpu_req.addr[3 +: IDX_W];
    assign tag   = cpu_req.addr[3 + IDX_W +: TAG_W];
    assign hit   = line_valid[index] && (tag_q[index] == tag);

    // read miss fills on the ram's done, stores only touch present lines
    assign refill = cpu_req.valid && !cpu_req.wen && !hit && mem_rsp.done;
    assign update = cpu_req.valid && cpu_req.wen && hit && mem_rsp.done;

    always_comb begin
        mem_req       = cpu_req;
        mem_req.valid = cpu_req.valid && (cpu_req.wen || !hit);  // write through
        mem_req.mask  = cpu_req.wen ? cpu_req.mask : 8'hff;
        cpu_rsp.done  = cpu_req.valid && ((!cpu_req.wen && hit) || mem_rsp.done);
        cpu_rsp.rdata = hit ? data_q[index] : mem_rsp.rdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else if (refill) begin
            line_valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            tag_q[index]  <= tag;
            data_q[index] <= mem_rsp.rdata;
        end else if (update) begin
            for (int b = 0; b < 8; b++) begin
                if (cpu_req.mask[b]) begin
                    data_q[index][8*b +: 8] <= cpu_req.wdata[8*b +: 8];  // merge lane
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LD  = 4'd1,
        LW  = 4'd2,
        LH  = 4'd3,
        LB  = 4'd4,
        LWU = 4'd5,
        LHU = 4'd6,
        LBU = 4'd7,
        SD  = 4'd8,
        SW  = 4'd9,
        SH  = 4'd10,
        SB  = 4'd11
    } mem_op_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SECOND = 2'd1,  // next doubleword of a crossing access
        DONE   = 2'd2
    } mem_state_e;

    typedef struct packed {
        logic        valid;
        logic        wen;
        logic [63:0] addr;   // doubleword aligned
        logic [63:0] wdata;
        logic [7:0]  mask;   // one bit per byte
    } cache_req_t;

    typedef struct packed {
        logic        done;   // one-cycle strobe
        logic [63:0] rdata;
    } cache_rsp_t;

endpackage

`default_nettype wire

//--- verilog/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// one doubleword per line
`define LSU_CACHE_LINES 16

// 512 doublewords, 4 KiB
`define LSU_RAM_WORDS_LOG2 9

// cycles from valid rise to done
`define LSU_RAM_LATENCY 2

`endif

//--- verilog/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
    input  wire                    clk,
    input  wire                    flush,
    input  wire                    valid_in,
    input  wire                    go,
    input  wire  [63:0]            addr,
    input  wire  [63:0]            store_data,
    input  wire  lsu_pkg::mem_op_e op,
    output logic                   valid_out,
    output logic                   ok,
    output logic [63:0]            load_data
);
    import lsu_pkg::*;

    cache_req_t cpu_req;
    cache_rsp_t cpu_rsp;
    cache_req_t mem_req;
    cache_rsp_t mem_rsp;
    logic       rst_n_sync;   // from the stage's synchronizer

    mem_access_unit mau_i (
        .clk        (clk),
        .flush      (flush),
        .valid_in   (valid_in),
        .go         (go),
        .addr       (addr),
        .store_data (store_data),
        .op         (op),
        .valid_out  (valid_out),
        .ok         (ok),
        .load_data  (load_data),
        .cache_req  (cpu_req),
        .cache_rsp  (cpu_rsp),
        .rst_n_sync (rst_n_sync)
    );

    dcache dcache_i (
        .clk     (clk),
        .rst_n   (rst_n_sync),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    data_ram ram_i (
        .clk   (clk),
        .rst_n (rst_n_sync),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

//--- verilog/mem_access_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access_unit (
    input  wire                       clk,
    input  wire                       flush,
    input  wire                       valid_in,
    input  wire                       go,
    input  wire  [63:0]               addr,
    input  wire  [63:0]               store_data,
    input  wire  lsu_pkg::mem_op_e    op,
    output logic                      valid_out,
    output logic                      ok,
    output logic [63:0]               load_data,
    output lsu_pkg::cache_req_t       cache_req,
    input  wire  lsu_pkg::cache_rsp_t cache_rsp,
    output logic                      rst_n_sync
);
    import lsu_pkg::*;

    logic [1:0]   rst_chain;
    mem_state_e   state;
    logic         pending;      // first request issued, no done yet
    logic         start;
    logic         is_store;
    logic [2:0]   offset;
    logic [7:0]   width_mask;
    logic [15:0]  span;         // byte lanes over both doublewords
    logic [127:0] wide_data;
    logic         crossing;
    logic [63:0]  rdata_lo;
    logic [63:0]  rdata_hi;
    logic [127:0] pair_shifted;
    logic [63:0]  aligned;

    // async assert, sync release
    always_ff @(posedge clk or negedge flush) begin
        if (!flush) begin
            rst_chain <= 2'b00;
        end else begin
            rst_chain <= {rst_chain[0], 1'b1};
        end
    end

    assign rst_n_sync = rst_chain[1];

    assign offset   = addr[2:0];
    assign start    = valid_in && go && (op != NOP);
    assign is_store = (op == SD) || (op == SW) || (op == SH) || (op == SB);

    always_comb begin
        case (op)
            LD, SD:      width_mask = 8'hff;
            LW, LWU, SW: width_mask = 8'h0f;
            LH, LHU, SH: width_mask = 8'h03;
            LB, LBU, SB: width_mask = 8'h01;
            default:     width_mask = 8'h00;
        endcase
    end

    assign span      = {8'h00, width_mask} << offset;
    assign wide_data = {64'd0, store_data} << {offset, 3'b000};
    assign crossing  = |span[15:8];

    always_comb begin
        cache_req.wen = is_store;
        if (state == SECOND) begin
            cache_req.valid = 1'b1;  // runs to completion
            cache_req.addr  = {addr[63:3] + 61'd1, 3'b000};
            cache_req.wdata = wide_data[127:64];
            cache_req.mask  = span[15:8];
        end else begin
            cache_req.valid = (state == IDLE) && (start || pending);
            cache_req.addr  = {addr[63:3], 3'b000};
            cache_req.wdata = wide_data[63:0];
            cache_req.mask  = span[7:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            state   <= IDLE;
            pending <= 1'b0;
        end else begin
            pending <= (state == IDLE) && cache_req.valid && !cache_rsp.done;
            case (state)
                IDLE: begin
                    if (cache_req.valid && cache_rsp.done) begin
                        state <= crossing ? SECOND : DONE;
                    end
                end
                SECOND: begin
                    if (cache_rsp.done) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cache_req.valid && cache_rsp.done) begin
            if (state == SECOND) begin
                rdata_hi <= cache_rsp.rdata;
            end else begin
                rdata_lo <= cache_rsp.rdata;
            end
        end
    end

    // bring the addressed byte down to lane 0
    assign pair_shifted = {rdata_hi, rdata_lo} >> {offset, 3'b000};
    assign aligned      = pair_shifted[63:0];

    always_comb begin
        case (op)
            LD:      load_data = aligned;
            LW:      load_data = {{32{aligned[31]}}, aligned[31:0]};
            LH:      load_data = {{48{aligned[15]}}, aligned[15:0]};
            LB:      load_data = {{56{aligned[7]}}, aligned[7:0]};
            LWU:     load_data = {32'd0, aligned[31:0]};
            LHU:     load_data = {48'd0, aligned[15:0]};
            LBU:     load_data = {56'd0, aligned[7:0]};
            default: load_data = 64'd0;
        endcase
    end

    always_comb begin
        case (state)
            IDLE: begin
                valid_out = valid_in && go && (op == NOP);  // nop passes straight through
                ok        = !(start || pending);
            end
            SECOND: begin
                valid_out = 1'b0;
                ok        = 1'b0;
            end
            default: begin
                valid_out = 1'b1;
                ok        = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire
